// File: source/lvdc_pkg.sv
package lvdc_pkg;

    // strobes from the oscillator buffer ring
    localparam int STROBE_W = 3;
    localparam int BO1_IDX  = 0;
    localparam int BO2_IDX  = 1;
    localparam int BO3_IDX  = 2;

    // bit times per phase, two per Johnson stage
    localparam int BIT_TIMES  = 14;
    localparam int BIT_TIME_W = BIT_TIMES / 2;

    // phase number, Gray coded
    localparam int PHASE_W = 3;

    typedef logic [STROBE_W-1:0]   strobe_t;    // bo3..bo1
    typedef logic [BIT_TIME_W-1:0] bit_time_t;  // g7..g1
    typedef logic [PHASE_W-1:0]    phase_t;     // pc..pa

    localparam strobe_t STROBE_IDLE = '0;
    localparam strobe_t STROBE_BO1  = strobe_t'(1) << BO1_IDX;
    localparam strobe_t STROBE_BO2  = strobe_t'(1) << BO2_IDX;
    localparam strobe_t STROBE_BO3  = strobe_t'(1) << BO3_IDX;

    localparam bit_time_t BIT_TIME_FIRST = '0;
    // only g7 set, the state just before the counter wraps to zero
    localparam bit_time_t BIT_TIME_LAST  = bit_time_t'(1) << (BIT_TIME_W - 1);

    localparam phase_t PHASE_FIRST = '0;

endpackage

// File: source/clock_bus_if.sv
`timescale 1ns/1ps
`default_nettype none

// P/Q/R clock pulses of one bit time, plus the level that brackets a run
interface clock_bus_if;

    logic p;
    logic q;
    logic r;
    logic active;

    modport source (
        output p,
        output q,
        output r,
        output active
    );

    modport sink (
        input p,
        input q,
        input r,
        input active
    );

endinterface

`default_nettype wire

// File: source/osc_buf.sv
`timescale 1ns/1ps
`default_nettype none

module osc_buf (
    input  logic              osc,
    input  logic              arst_n,
    input  logic              run,
    output lvdc_pkg::strobe_t strobe
);

    // three stage ring, loads only when empty and empties only after bo3
    always_ff @(posedge osc or negedge arst_n) begin
        if (!arst_n) begin
            strobe <= lvdc_pkg::STROBE_IDLE;
        end else begin
            case (strobe)
                lvdc_pkg::STROBE_IDLE: begin
                    if (run) begin
                        strobe <= lvdc_pkg::STROBE_BO1;  // start of a bit time
                    end
                end
                lvdc_pkg::STROBE_BO1: begin
                    strobe <= lvdc_pkg::STROBE_BO2;
                end
                lvdc_pkg::STROBE_BO2: begin
                    strobe <= lvdc_pkg::STROBE_BO3;
                end
                lvdc_pkg::STROBE_BO3: begin
                    if (run) begin
                        strobe <= lvdc_pkg::STROBE_BO1;
                    end else begin
                        strobe <= lvdc_pkg::STROBE_IDLE;  // bit time complete, stop here
                    end
                end
                default: begin
                    strobe <= lvdc_pkg::STROBE_IDLE;  // recover from a broken ring
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// File: source/clock_logic.sv
`timescale 1ns/1ps
`default_nettype none

module clock_logic (
    input  logic              osc,
    input  logic              arst_n,
    input  lvdc_pkg::strobe_t strobe,
    clock_bus_if.source       bus
);

    logic bo1;
    logic bo2;
    logic bo3;

    assign bo1 = strobe[lvdc_pkg::BO1_IDX];
    assign bo2 = strobe[lvdc_pkg::BO2_IDX];
    assign bo3 = strobe[lvdc_pkg::BO3_IDX];

    // P, Q and R pulses trail the strobes by one cycle
    always_ff @(posedge osc or negedge arst_n) begin
        if (!arst_n) begin
            bus.p <= 1'b0;
            bus.q <= 1'b0;
            bus.r <= 1'b0;
        end else begin
            bus.p <= bo1;
            bus.q <= bo2;
            bus.r <= bo3;
        end
    end

    // rises together with the first p of a run,
    // falls after the r whose next strobe is not bo1
    always_ff @(posedge osc or negedge arst_n) begin
        if (!arst_n) begin
            bus.active <= 1'b0;
        end else begin
            if (bo1) begin
                bus.active <= 1'b1;
            end else if (bus.r) begin
                bus.active <= 1'b0;  // ring went idle
            end
        end
    end

endmodule

`default_nettype wire

// File: source/clock_drivers.sv
`timescale 1ns/1ps
`default_nettype none

module clock_drivers (
    input  logic      osc,
    input  logic      arst_n,
    clock_bus_if.sink bus,
    output logic      w7,
    output logic      y5
);

    logic started;  // sync already sent in this run

    always_ff @(posedge osc or negedge arst_n) begin
        if (!arst_n) begin
            started <= 1'b0;
        end else begin
            if (!bus.active) begin
                started <= 1'b0;
            end else if (bus.p) begin
                started <= 1'b1;
            end
        end
    end

    // y5 lands on q of the first bit time, w7 on the cycle after each r
    always_ff @(posedge osc or negedge arst_n) begin
        if (!arst_n) begin
            y5 <= 1'b0;
            w7 <= 1'b0;
        end else begin
            y5 <= bus.p && bus.active && !started;
            w7 <= bus.r;
        end
    end

endmodule

`default_nettype wire

// File: source/timing.sv
`timescale 1ns/1ps
`default_nettype none

module timing (
    input  logic                osc,
    input  logic                arst_n,
    input  logic                w7,
    input  logic                y5,
    output lvdc_pkg::bit_time_t bit_time,
    output lvdc_pkg::phase_t    phase,
    output logic                a
);

    lvdc_pkg::bit_time_t bit_time_nxt;
    lvdc_pkg::phase_t    phase_nxt;

    // next Gray code, by way of binary
    function automatic lvdc_pkg::phase_t gray_next(input lvdc_pkg::phase_t g);
        lvdc_pkg::phase_t bin;
        bin[lvdc_pkg::PHASE_W-1] = g[lvdc_pkg::PHASE_W-1];
        for (int i = lvdc_pkg::PHASE_W - 2; i >= 0; i--) begin
            bin[i] = bin[i+1] ^ g[i];
        end
        bin = bin + 1'b1;
        return bin ^ (bin >> 1);
    endfunction

    // Johnson step, shift in the inverse of g7
    assign bit_time_nxt = {bit_time[lvdc_pkg::BIT_TIME_W-2:0],
                           ~bit_time[lvdc_pkg::BIT_TIME_W-1]};

    assign phase_nxt = gray_next(phase);

    always_ff @(posedge osc or negedge arst_n) begin
        if (!arst_n) begin
            bit_time <= lvdc_pkg::BIT_TIME_FIRST;
            phase    <= lvdc_pkg::PHASE_FIRST;
        end else begin
            if (y5) begin
                bit_time <= lvdc_pkg::BIT_TIME_FIRST;  // start-up sync
                phase    <= lvdc_pkg::PHASE_FIRST;
            end else if (w7) begin
                bit_time <= bit_time_nxt;
                if (bit_time == lvdc_pkg::BIT_TIME_LAST) begin
                    phase <= phase_nxt;  // wrapped past bit time 14
                end
            end
        end
    end

    assign a = (bit_time == lvdc_pkg::BIT_TIME_LAST);

endmodule

`default_nettype wire

// File: source/lvdc_timing.sv
`timescale 1ns/1ps
`default_nettype none

module lvdc_timing (
    input  logic                osc,
    input  logic                arst_n,
    input  logic                run,
    output logic                p,
    output logic                q,
    output logic                r,
    output logic                sync,
    output lvdc_pkg::bit_time_t bit_time,
    output lvdc_pkg::phase_t    phase,
    output logic                a
);

    lvdc_pkg::strobe_t strobe;
    logic              w7;
    logic              y5;

    clock_bus_if cbus ();

    osc_buf a4a11 (
        .osc    (osc),
        .arst_n (arst_n),
        .run    (run),
        .strobe (strobe)
    );

    clock_logic a4a12 (
        .osc    (osc),
        .arst_n (arst_n),
        .strobe (strobe),
        .bus    (cbus.source)
    );

    clock_drivers a1a3 (
        .osc    (osc),
        .arst_n (arst_n),
        .bus    (cbus.sink),
        .w7     (w7),
        .y5     (y5)
    );

    timing a1a13 (
        .osc      (osc),
        .arst_n   (arst_n),
        .w7       (w7),
        .y5       (y5),
        .bit_time (bit_time),
        .phase    (phase),
        .a        (a)
    );

    assign p    = cbus.p;
    assign q    = cbus.q;
    assign r    = cbus.r;
    assign sync = y5;  // start-up sync to the backplane

endmodule

`default_nettype wire

// File: dv/lvdc_timing_tb.sv
`timescale 1ns/1ps

module lvdc_timing_tb;

    localparam int          CLK_PERIOD   = 8;
    localparam int          RESET_CYCLES = 10;
    localparam int          IDLE_CYCLES  = 10;
    localparam int          INTERVALS    = 40;
    localparam int          MIN_LEN      = 4;
    localparam int          MAX_LEN      = 200;
    localparam logic [31:0] SEED         = 32'h7e9cc660;

    logic                osc;
    logic                arst_n;
    logic                run;
    logic                p;
    logic                q;
    logic                r;
    logic                sync;
    lvdc_pkg::bit_time_t bit_time;
    lvdc_pkg::phase_t    phase;
    logic                a;

    // reference model state
    int                  m_stage;  // 0 idle, 1..3 while bo1..bo3 strobe
    logic                m_fresh;  // ring just started, sync still owed
    logic                m_p;
    logic                m_q;
    logic                m_r;
    logic                m_sync;
    logic                m_w7;
    int                  m_count;  // bit time within phase, 0..13
    lvdc_pkg::bit_time_t m_john;
    lvdc_pkg::phase_t    m_phase_bin;

    int                  n_p;
    int                  n_q;
    int                  n_r;
    int                  n_sync;
    int                  total_sync;
    int                  high_len[INTERVALS];
    int                  low_len[INTERVALS];
    int                  total_cycles;
    logic [31:0]         rnd;

    lvdc_timing i_dut (
        .osc      (osc),
        .arst_n   (arst_n),
        .run      (run),
        .p        (p),
        .q        (q),
        .r        (r),
        .sync     (sync),
        .bit_time (bit_time),
        .phase    (phase),
        .a        (a)
    );

    initial osc = 1'b0;
    always #(CLK_PERIOD / 2) osc = ~osc;

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic int pick_length(input logic [31:0] s);
        return MIN_LEN + int'(s[30:15]) % (MAX_LEN - MIN_LEN + 1);
    endfunction

    function automatic lvdc_pkg::phase_t gray_of(input lvdc_pkg::phase_t bin);
        return bin ^ (bin >> 1);
    endfunction

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("Some tests failed");
        $fatal(1, "stopped at first error");
    endtask

    task automatic compare_value(input string name, input logic [31:0] expected,
                                 input logic [31:0] actual);
        assert (actual === expected) else
            abort_run($sformatf("Fail %s expected %h actual %h", name, expected, actual));
    endtask

    // model advances on the same edge the DUT samples run
    always @(posedge osc) begin
        if (!arst_n) begin
            m_stage     = 0;
            m_fresh     = 1'b0;
            m_p         = 1'b0;
            m_q         = 1'b0;
            m_r         = 1'b0;
            m_sync      = 1'b0;
            m_w7        = 1'b0;
            m_count     = 0;
            m_john      = '0;
            m_phase_bin = '0;
        end else begin
            if (m_sync) begin
                m_count     = 0;
                m_john      = '0;
                m_phase_bin = '0;
            end else if (m_w7) begin
                if (m_count == lvdc_pkg::BIT_TIMES - 1) begin
                    m_count     = 0;
                    m_phase_bin = m_phase_bin + 3'd1;  // next phase
                end else begin
                    m_count = m_count + 1;
                end
                m_john = {m_john[lvdc_pkg::BIT_TIME_W-2:0], ~m_john[lvdc_pkg::BIT_TIME_W-1]};
            end
            m_w7   = m_r;
            m_sync = m_p && m_fresh;
            if (m_sync) begin
                m_fresh = 1'b0;
            end
            m_p = (m_stage == 1);
            m_q = (m_stage == 2);
            m_r = (m_stage == 3);
            if (m_stage == 0 || m_stage == 3) begin
                if (run) begin
                    if (m_stage == 0) begin
                        m_fresh = 1'b1;  // new start from idle
                    end
                    m_stage = 1;
                end else begin
                    m_stage = 0;
                end
            end else begin
                m_stage = m_stage + 1;
            end
        end
    end

    // outputs are settled mid cycle
    always @(negedge osc) begin
        compare_value("p", 32'(m_p), 32'(p));
        compare_value("q", 32'(m_q), 32'(q));
        compare_value("r", 32'(m_r), 32'(r));
        compare_value("sync", 32'(m_sync), 32'(sync));
        compare_value("bit_time", 32'(m_john), 32'(bit_time));
        compare_value("phase", 32'(gray_of(m_phase_bin)), 32'(phase));
        compare_value("a", 32'(m_count == lvdc_pkg::BIT_TIMES - 1), 32'(a));
        assert ($onehot0({p, q, r})) else
            abort_run("more than one of p, q and r was high in the same cycle");
        if (p) n_p = n_p + 1;
        if (q) n_q = n_q + 1;
        if (r) n_r = n_r + 1;
        if (sync) begin
            n_sync     = n_sync + 1;
            total_sync = total_sync + 1;
        end
    end

    task automatic hold_run(input logic value, input int cycles);
        run = value;
        repeat (cycles) @(posedge osc);
        #1;
    endtask

    task automatic check_interval();
        assert (n_p == n_q && n_q == n_r) else
            abort_run("p, q and r pulse counts differ within one run interval");
        assert (n_p > 0) else
            abort_run("no bit time ran while run was high");
        assert (n_sync == 1) else
            abort_run("sync did not pulse exactly once in a run interval");
        n_p    = 0;
        n_q    = 0;
        n_r    = 0;
        n_sync = 0;
    endtask

    initial begin
        arst_n       = 1'b0;
        run          = 1'b0;
        n_p          = 0;
        n_q          = 0;
        n_r          = 0;
        n_sync       = 0;
        total_sync   = 0;
        total_cycles = RESET_CYCLES + IDLE_CYCLES + 20;
        rnd          = SEED;
        for (int i = 0; i < INTERVALS; i++) begin
            rnd          = lcg_next(rnd);
            high_len[i]  = pick_length(rnd);
            rnd          = lcg_next(rnd);
            low_len[i]   = pick_length(rnd);
            total_cycles = total_cycles + high_len[i] + low_len[i];
        end
        repeat (RESET_CYCLES) @(posedge osc);
        #1;
        arst_n = 1'b1;
        hold_run(1'b0, IDLE_CYCLES);  // quiet after reset, run still low
        check_interval_idle: assert (n_p == 0 && n_sync == 0) else
            abort_run("clock pulses appeared before run was raised");
        for (int i = 0; i < INTERVALS; i++) begin
            hold_run(1'b1, high_len[i]);
            hold_run(1'b0, low_len[i]);
            check_interval();
        end
        repeat (20) @(posedge osc);
        assert (total_sync == INTERVALS) else
            abort_run("number of sync pulses does not match the number of starts");
        $display("All tests passed");
        $finish;
    end

    initial begin
        int limit_ns;
        #1;
        limit_ns = (total_cycles + 1000) * CLK_PERIOD;
        #(limit_ns);
        abort_run("Timeout: the run did not finish within the watchdog limit");
    end

endmodule

// File: all.f
source/lvdc_pkg.sv
source/clock_bus_if.sv
source/osc_buf.sv
source/clock_logic.sv
source/clock_drivers.sv
source/timing.sv
source/lvdc_timing.sv
dv/lvdc_timing_tb.sv

// File: Makefile
VERILATOR = verilator
FLAGS     = --binary --timing -Wno-fatal
TOP       = lvdc_timing_tb
FILELIST  = all.f
BUILD_DIR = obj_dir
PASS_MSG  = All tests passed

.PHONY: simulate clean

simulate:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)
